/* project.f */
+incdir+bench
rtl/aluPkg.sv
rtl/operandStage.sv
rtl/bcdDigit.sv
rtl/aluCore.sv
rtl/resultStage.sv
rtl/executeUnit.sv
bench/tb_executeUnit.sv

/* Makefile */
SIM := obj_dir/Vtb_executeUnit

.PHONY: all run clean

all: run

$(SIM): project.f $(wildcard rtl/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_executeUnit -o Vtb_executeUnit

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/aluModel.svh */
// ====================
// reference model of the execute unit ops and psw flags
// ====================
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// value of the low bcd digits of a word
function automatic int bcdValue(input word_t bcd, input int digits);
	int val;
	val = 0;
	for (int k = digits - 1; k >= 0; k--) begin
		val = val * 10 + int'((bcd >> (4 * k)) & 16'h000F);
	end
	return val;
endfunction

function automatic word_t bcdWord(input int val, input int digits);
	word_t w;
	w = '0;
	for (int k = 0; k < digits; k++) begin
		w[4*k +: 4] = 4'(val % 10);
		val = val / 10;
	end
	return w;
endfunction

task automatic modelOp(input aluReq_t r, input word_t pswIn, output word_t res,
		output logic wb, output word_t pswOut);
	aluOp_t kind;
	int w;
	int mask;
	int top;	// sign bit of the form
	int d;
	int s;
	int cin;
	int full;
	int bitNo;
	int dec;
	logic c;
	logic v;
	logic defC;
	logic defV;
	logic defNZ;
	kind = {r.op[4:1], 1'b0};
	w = r.op[0] ? 8 : 16;
	mask = (1 << w) - 1;
	top = 1 << (w - 1);
	d = int'(r.dst) & mask;
	s = int'(r.src) & mask;
	cin = (kind == OP_ADDC || kind == OP_SUBC) ? int'(pswIn[0]) : 0;
	if (kind == OP_SUB || kind == OP_CMP) begin
		cin = 1;	// plain subtract never borrows in
	end
	full = d;
	c = 1'b0;
	v = 1'b0;
	defC = 1'b0;
	defV = 1'b0;
	defNZ = 1'b1;
	case (kind)
		OP_ADD, OP_ADDC: begin
			full = d + s + cin;
			v = ((d & top) == (s & top)) && ((full & top) != (d & top));
			c = (full > mask);
			defC = 1'b1;
			defV = 1'b1;
		end
		OP_SUB, OP_SUBC, OP_CMP: begin
			full = d + (~s & mask) + cin;
			v = ((d & top) != (s & top)) && ((full & top) != (d & top));	// signed d - s
			c = (full > mask);	// set means no borrow
			defC = 1'b1;
			defV = 1'b1;
		end
		OP_DADD: begin
			dec = bcdValue(r.dst, w / 4) + bcdValue(r.src, w / 4) + int'(pswIn[0]);
			c = (dec >= ((w == 8) ? 100 : 10000));
			full = int'(bcdWord(dec, w / 4));
			defC = 1'b1;
			defNZ = 1'b0;
		end
		OP_XOR: full = d ^ s;
		OP_AND: full = d & s;
		OP_OR: full = d | s;
		OP_BIT, OP_BIC, OP_BIS: begin
			bitNo = (int'(r.src) > w - 1) ? w - 1 : int'(r.src);
			if (kind == OP_BIT) begin
				full = d & (1 << bitNo);
			end else if (kind == OP_BIC) begin
				full = d & ~(1 << bitNo);
			end else begin
				full = d | (1 << bitNo);
			end
		end
		OP_SRA: begin
			full = (d >> 1) | (d & top);
			defNZ = 1'b0;
		end
		OP_RRC: begin
			full = (d >> 1) | (pswIn[0] ? top : 0);
			c = d[0];
			defC = 1'b1;
			defNZ = 1'b0;
		end
		default: ;
	endcase
	res = r.op[0] ? {r.dst[15:8], byte_t'(full)} : word_t'(full);
	wb = !(kind == OP_CMP || kind == OP_BIT);
	pswOut = pswIn;
	if (r.pswUpdate) begin
		if (defC) pswOut[0] = c;
		if (defV) pswOut[4] = v;
		if (defNZ) begin
			pswOut[2] = ((full & top) != 0);	// n
			pswOut[1] = ((full & mask) == 0);	// z
		end
	end
endtask

`endif

/* bench/tb_executeUnit.sv */
// ====================
// execute unit testbench
// random requests checked against the reference model
// ====================
`timescale 1ns/1ps

module tb_executeUnit;
	import aluPkg::*;

	`include "aluModel.svh"

	typedef struct packed {
		word_t result;
		logic wb;
		word_t psw;
	} expect_t;

	logic E;
	logic rst;
	logic valid;
	aluReq_t req;
	logic pswLoad;
	word_t pswValue;
	word_t result;
	logic writeBack;
	logic resultValid;
	word_t psw;

	expect_t expQ[$];
	aluReq_t mStageReq;	// model copy of the stage register
	logic mStageValid;
	word_t mPsw;
	string testName;
	int testChecks;
	int testErrors;
	int totalChecks;
	int totalErrors;
	int testCount;
	logic sawValid;

	aluOp_t arithOps[5] = '{OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_CMP};
	aluOp_t logicOps[6] = '{OP_XOR, OP_AND, OP_OR, OP_BIT, OP_BIC, OP_BIS};
	aluOp_t shiftOps[2] = '{OP_SRA, OP_RRC};
	aluOp_t allOps[14] = '{OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_DADD, OP_CMP, OP_XOR,
		OP_AND, OP_OR, OP_BIT, OP_BIC, OP_BIS, OP_SRA, OP_RRC};

	executeUnit dut_i (
		.E(E),
		.rst_i(rst),
		.valid_i(valid),
		.req_i(req),
		.pswLoad_i(pswLoad),
		.pswValue_i(pswValue),
		.result_o(result),
		.writeBack_o(writeBack),
		.resultValid_o(resultValid),
		.psw_o(psw)
	);

	initial begin
		E = 1'b0;
		forever #4 E = ~E;
	end

	task automatic reportMismatch(input string what, input word_t expected, input word_t actual);
		$display("ERROR %s: %s expected %h actual %h", testName, what, expected, actual);
		testErrors++;
	endtask

	// outputs are stable at the falling edge
	task automatic checkOutputs();
		expect_t e;
		sawValid = resultValid;
		if (!resultValid) begin
			if (writeBack !== 1'b0) begin
				$display("%s: writeBack_o is high without a result", testName);
				testErrors++;
			end
		end else if (expQ.size() == 0) begin
			$display("%s: a result arrived with no request pending", testName);
			testErrors++;
		end else begin
			e = expQ.pop_front();
			testChecks++;
			if (result !== e.result) reportMismatch("result", e.result, result);
			if (writeBack !== e.wb) reportMismatch("writeBack", word_t'(e.wb), word_t'(writeBack));
			if (psw !== e.psw) reportMismatch("psw", e.psw, psw);
		end
	endtask

	// one cycle: check, drive, then advance the model past the next rising edge
	task automatic tick(input logic v, input aluReq_t r, input logic ld, input word_t lv);
		word_t res;
		logic wb;
		word_t nextPsw;
		expect_t e;
		@(negedge E);
		checkOutputs();
		valid = v;
		req = r;
		pswLoad = ld;
		pswValue = lv;
		if (mStageValid) begin
			modelOp(mStageReq, mPsw, res, wb, nextPsw);
			mPsw = ld ? lv : nextPsw;	// load beats the flag write
			e.result = res;
			e.wb = wb;
			e.psw = mPsw;
			expQ.push_back(e);
		end else if (ld) begin
			mPsw = lv;
		end
		mStageValid = v;
		if (v) mStageReq = r;
	endtask

	task automatic idleCycle();
		tick(1'b0, '0, 1'b0, '0);
	endtask

	function automatic word_t randomBcd();
		word_t w;
		for (int k = 0; k < NUM_DIGITS; k++) begin
			w[4*k +: 4] = 4'($urandom_range(0, 9));
		end
		return w;
	endfunction

	function automatic aluReq_t randomReq(input aluOp_t kind);
		aluReq_t r;
		r.op = kind | aluOp_t'($urandom_range(0, 1));	// random byte form
		r.pswUpdate = 1'($urandom_range(0, 1));
		r.dst = word_t'($urandom);
		r.src = word_t'($urandom);
		if (kind == OP_DADD) begin
			r.dst = randomBcd();
			r.src = randomBcd();
		end else if (kind inside {OP_BIT, OP_BIC, OP_BIS} && $urandom_range(0, 1) == 1) begin
			r.src = word_t'($urandom_range(0, 20));	// near the cap
		end
		return r;
	endfunction

	task automatic startTest(input string name);
		testName = name;
		testChecks = 0;
		testErrors = 0;
	endtask

	// drain the pipeline, then report the test
	task automatic endTest();
		int waitCycles;
		waitCycles = 0;
		while ((expQ.size() != 0 || mStageValid) && waitCycles < 20) begin
			idleCycle();
			waitCycles++;
		end
		if (expQ.size() != 0 || mStageValid) begin
			$display("%s: timed out waiting for pending results", testName);
			testErrors++;
			expQ.delete();
		end
		$display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
		testCount++;
		totalChecks += testChecks;
		totalErrors += testErrors;
	endtask

	initial begin
		int cnt;
		aluReq_t dirReq;
		void'($urandom(33014));
		rst = 1'b1;
		valid = 1'b0;
		req = '0;
		pswLoad = 1'b0;
		pswValue = '0;
		mStageValid = 1'b0;
		mStageReq = '0;
		mPsw = '0;
		totalChecks = 0;
		totalErrors = 0;
		testCount = 0;
		repeat (8) @(posedge E);
		@(negedge E);
		rst = 1'b0;

		startTest("resetLatency");
		idleCycle();
		testChecks++;
		if (resultValid !== 1'b0 || writeBack !== 1'b0) begin
			$display("%s: outputs are not quiet after reset", testName);
			testErrors++;
		end
		if (psw !== '0) reportMismatch("psw after reset", '0, psw);
		tick(1'b1, randomReq(OP_ADD), 1'b0, '0);
		cnt = 0;
		sawValid = 1'b0;
		while (!sawValid && cnt < 10) begin
			idleCycle();
			cnt++;
		end
		testChecks++;
		if (!sawValid) begin
			$display("%s: no result within 10 cycles", testName);
			testErrors++;
		end else if (cnt != 2) begin
			reportMismatch("latency", word_t'(2), word_t'(cnt));
		end
		endTest();

		startTest("arithmetic");
		repeat (200) tick(1'b1, randomReq(arithOps[$urandom_range(0, 4)]), 1'b0, '0);
		endTest();

		startTest("logicAndBits");
		repeat (200) tick(1'b1, randomReq(logicOps[$urandom_range(0, 5)]), 1'b0, '0);
		endTest();

		startTest("decimalAdd");
		repeat (150) tick(1'b1, randomReq(OP_DADD), 1'($urandom_range(0, 1)), word_t'($urandom));
		endTest();

		startTest("shifts");
		repeat (150) tick(1'b1, randomReq(shiftOps[$urandom_range(0, 1)]), 1'b0, '0);
		endTest();

		startTest("gapsAndLoads");
		repeat (300) begin
			tick($urandom_range(0, 2) != 0, randomReq(allOps[$urandom_range(0, 13)]),
				$urandom_range(0, 4) == 0, word_t'($urandom));
		end
		dirReq = randomReq(OP_ADD);
		dirReq.pswUpdate = 1'b1;
		tick(1'b1, dirReq, 1'b0, '0);
		tick(1'b0, '0, 1'b1, 16'hA5A5);	// load lands on the add's flag write
		endTest();

		$display("tests %0d, checks %0d, errors %0d", testCount, totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* rtl/executeUnit.sv */
// ====================
// execute unit top
// ====================
`timescale 1ns/1ps

module executeUnit (
	input  logic E,
	input  logic rst_i,
	input  logic valid_i,
	input  aluPkg::aluReq_t req_i,
	input  logic pswLoad_i,
	input  aluPkg::word_t pswValue_i,
	output aluPkg::word_t result_o,
	output logic writeBack_o,
	output logic resultValid_o,
	output aluPkg::word_t psw_o
);
	import aluPkg::*;

	aluReq_t stageReq;
	logic stageValid;
	digit_t [NUM_DIGITS-1:0] dstDigit;
	digit_t [NUM_DIGITS-1:0] srcDigit;
	digit_t [NUM_DIGITS-1:0] digitSum;
	logic [NUM_DIGITS:0] carryChain;	// bit k feeds cell k
	aluOut_t coreOut;

	assign carryChain[0] = psw_o[0];	// decimal carry in is psw C

	operandStage operand_i (
		.E(E),
		.rst_i(rst_i),
		.valid_i(valid_i),
		.req_i(req_i),
		.stageReq_o(stageReq),
		.stageValid_o(stageValid),
		.dstDigit_o(dstDigit),
		.srcDigit_o(srcDigit)
	);

	aluCore core_i (
		.stageReq_i(stageReq),
		.psw_i(psw_o),
		.out_o(coreOut)
	);

	for (genvar k = 0; k < NUM_DIGITS; k++) begin : gDigit
		bcdDigit digit_i (
			.a_i(dstDigit[k]),
			.b_i(srcDigit[k]),
			.carry_i(carryChain[k]),
			.sum_o(digitSum[k]),
			.carry_o(carryChain[k+1])
		);
	end

	resultStage result_i (
		.E(E),
		.rst_i(rst_i),
		.stageReq_i(stageReq),
		.stageValid_i(stageValid),
		.core_i(coreOut),
		.digitSum_i(digitSum),
		.digitCarry_i(carryChain[NUM_DIGITS:1]),
		.pswLoad_i(pswLoad_i),
		.pswValue_i(pswValue_i),
		.result_o(result_o),
		.writeBack_o(writeBack_o),
		.resultValid_o(resultValid_o),
		.psw_o(psw_o)
	);

endmodule

/* rtl/resultStage.sv */
// ====================
// result stage
// result select, flag merge, psw and output registers
// ====================
`timescale 1ns/1ps

module resultStage (
	input  logic E,
	input  logic rst_i,
	input  aluPkg::aluReq_t stageReq_i,
	input  logic stageValid_i,
	input  aluPkg::aluOut_t core_i,
	input  aluPkg::digit_t [aluPkg::NUM_DIGITS-1:0] digitSum_i,
	input  logic [aluPkg::NUM_DIGITS-1:0] digitCarry_i,
	input  logic pswLoad_i,
	input  aluPkg::word_t pswValue_i,
	output aluPkg::word_t result_o,
	output logic writeBack_o,
	output logic resultValid_o,
	output aluPkg::word_t psw_o
);
	import aluPkg::*;

	aluOp_t baseOp;
	logic byteOp;
	logic isDadd;
	logic storesResult;	// cmp and bit only set flags
	word_t daddResult;
	logic daddCarry;
	word_t finalResult;
	flags_t oldFlags;
	flags_t newFlags;
	word_t nextPsw;

	always_comb begin
		baseOp = {stageReq_i.op[4:1], 1'b0};
		byteOp = stageReq_i.op[0];
		isDadd = (baseOp == OP_DADD);
		storesResult = !(baseOp inside {OP_CMP, OP_BIT});

		// byte dadd uses the low two digits only
		if (byteOp) begin
			daddResult = {stageReq_i.dst[15:8], digitSum_i[1], digitSum_i[0]};
			daddCarry = digitCarry_i[1];
		end else begin
			daddResult = word_t'(digitSum_i);
			daddCarry = digitCarry_i[NUM_DIGITS-1];
		end
		finalResult = isDadd ? daddResult : core_i.result;

		oldFlags = flags_t'(psw_o[4:0]);
		newFlags = oldFlags;	// undefined flags are kept
		if (stageValid_i && stageReq_i.pswUpdate) begin
			if (core_i.cValid) begin
				newFlags.c = isDadd ? daddCarry : core_i.flags.c;
			end
			if (core_i.vValid) begin
				newFlags.v = core_i.flags.v;
			end
			if (core_i.nzValid) begin
				newFlags.n = core_i.flags.n;
				newFlags.z = core_i.flags.z;
			end
		end
		nextPsw = {psw_o[15:5], newFlags};
	end

	always_ff @(posedge E) begin
		if (rst_i) begin
			resultValid_o <= 1'b0;
			writeBack_o <= 1'b0;
			psw_o <= '0;
		end else begin
			resultValid_o <= stageValid_i;
			writeBack_o <= stageValid_i && storesResult;
			psw_o <= pswLoad_i ? pswValue_i : nextPsw;	// a load beats the flag write
		end
	end

	always_ff @(posedge E) begin
		if (stageValid_i) begin
			result_o <= finalResult;
		end
	end

	// no result leaves in the first cycle after reset
	resetQuiet: assert property (
		@(posedge E) $fell(rst_i) |=> !resultValid_o && !writeBack_o
	);

endmodule

/* rtl/aluCore.sv */
// ====================
// binary alu core
// arithmetic, logic, bit and shift ops with flag candidates
// ====================
`timescale 1ns/1ps

module aluCore (
	input  aluPkg::aluReq_t stageReq_i,
	input  aluPkg::word_t psw_i,
	output aluPkg::aluOut_t out_o
);
	import aluPkg::*;

	aluOp_t baseOp;	// word-form opcode
	logic byteOp;
	word_t dst;
	word_t src;
	word_t addB;	// second adder operand, inverted for subtracts
	logic addCin;
	logic [16:0] wordSum;
	logic [8:0] byteSum;
	logic [3:0] bitNum;
	word_t bitMask;
	logic shiftIn;	// bit entering at the top on a right shift
	byte_t shiftByte;
	word_t raw;	// op result before the high byte merge
	word_t res;
	logic signDst;
	logic signB;
	logic signRes;

	always_comb begin
		baseOp = {stageReq_i.op[4:1], 1'b0};
		byteOp = stageReq_i.op[0];
		dst = stageReq_i.dst;
		src = stageReq_i.src;

		// subtract is dst + ~src + carry
		addB = (baseOp inside {OP_SUB, OP_SUBC, OP_CMP}) ? ~src : src;
		case (baseOp)
			OP_ADDC, OP_SUBC: addCin = psw_i[0];
			OP_SUB, OP_CMP: addCin = 1'b1;
			default: addCin = 1'b0;
		endcase
		wordSum = {1'b0, dst} + {1'b0, addB} + 17'(addCin);
		byteSum = {1'b0, dst[7:0]} + {1'b0, addB[7:0]} + 9'(addCin);

		// bit number capped at the top bit of the form
		if (byteOp) begin
			bitNum = (src > 16'd7) ? 4'd7 : src[3:0];
		end else begin
			bitNum = (src > 16'd15) ? 4'd15 : src[3:0];
		end
		bitMask = word_t'(1) << bitNum;

		// sra copies the sign, rrc pulls in C
		if (baseOp == OP_SRA) begin
			shiftIn = byteOp ? dst[7] : dst[15];
		end else begin
			shiftIn = psw_i[0];
		end
		shiftByte = {shiftIn, dst[7:1]};

		out_o = '0;
		raw = dst;	// dadd result is built downstream
		case (baseOp)
			OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_CMP: begin
				raw = byteOp ? {8'h00, byteSum[7:0]} : wordSum[15:0];
				out_o.flags.c = byteOp ? byteSum[8] : wordSum[16];
				out_o.cValid = 1'b1;
				out_o.vValid = 1'b1;
				out_o.nzValid = 1'b1;
			end
			OP_DADD: out_o.cValid = 1'b1;	// carry comes from the digit chain
			OP_XOR: begin
				raw = dst ^ src;
				out_o.nzValid = 1'b1;
			end
			OP_AND: begin
				raw = dst & src;
				out_o.nzValid = 1'b1;
			end
			OP_OR: begin
				raw = dst | src;
				out_o.nzValid = 1'b1;
			end
			OP_BIT: begin
				raw = dst & bitMask;
				out_o.nzValid = 1'b1;
			end
			OP_BIC: begin
				raw = dst & ~bitMask;
				out_o.nzValid = 1'b1;
			end
			OP_BIS: begin
				raw = dst | bitMask;
				out_o.nzValid = 1'b1;
			end
			OP_SRA: raw = byteOp ? {8'h00, shiftByte} : {shiftIn, dst[15:1]};	// flags untouched
			OP_RRC: begin
				raw = byteOp ? {8'h00, shiftByte} : {shiftIn, dst[15:1]};
				out_o.flags.c = dst[0];	// old lsb out to C
				out_o.cValid = 1'b1;
			end
			default: ;
		endcase

		res = byteOp ? {dst[15:8], raw[7:0]} : raw;	// byte form keeps dst high byte

		// overflow when like signs give an unlike result
		signDst = byteOp ? dst[7] : dst[15];
		signB = byteOp ? addB[7] : addB[15];
		signRes = byteOp ? res[7] : res[15];
		out_o.flags.v = (signDst == signB) && (signRes != signDst);
		out_o.flags.n = signRes;
		out_o.flags.z = byteOp ? (res[7:0] == 8'h00) : (res == 16'h0000);
		out_o.result = res;
	end

endmodule

/* rtl/bcdDigit.sv */
// ====================
// one bcd digit adder cell
// ====================
`timescale 1ns/1ps

module bcdDigit (
	input  aluPkg::digit_t a_i,
	input  aluPkg::digit_t b_i,
	input  logic carry_i,
	output aluPkg::digit_t sum_o,
	output logic carry_o
);

	logic [4:0] rawSum;	// binary sum, up to 19 for valid digits
	logic decCarry;

	always_comb begin
		rawSum = {1'b0, a_i} + {1'b0, b_i} + {4'd0, carry_i};
		decCarry = (rawSum > 5'd9);	// past nine wraps to next digit
		if (decCarry) begin
			sum_o = 4'(rawSum - 5'd10);
		end else begin
			sum_o = rawSum[3:0];
		end
		carry_o = decCarry;
	end

endmodule

/* rtl/operandStage.sv */
// ====================
// operand stage register
// and bcd digit split
// ====================
`timescale 1ns/1ps

module operandStage (
	input  logic E,
	input  logic rst_i,
	input  logic valid_i,
	input  aluPkg::aluReq_t req_i,
	output aluPkg::aluReq_t stageReq_o,
	output logic stageValid_o,
	output aluPkg::digit_t [aluPkg::NUM_DIGITS-1:0] dstDigit_o,
	output aluPkg::digit_t [aluPkg::NUM_DIGITS-1:0] srcDigit_o
);
	import aluPkg::*;

	// stage valid bit
	always_ff @(posedge E) begin
		if (rst_i) begin
			stageValid_o <= 1'b0;
		end else begin
			stageValid_o <= valid_i;
		end
	end

	// request payload holds while idle
	always_ff @(posedge E) begin
		if (valid_i) begin
			stageReq_o <= req_i;
		end
	end

	// digit k covers word bits 4k+3 down to 4k
	always_comb begin
		for (int k = 0; k < NUM_DIGITS; k++) begin
			dstDigit_o[k] = stageReq_o.dst[4*k +: 4];
			srcDigit_o[k] = stageReq_o.src[4*k +: 4];
		end
	end

	// an accepted request carries a legal opcode into the stage
	validOpcode: assert property (
		@(posedge E) disable iff (rst_i)
		valid_i |=> (stageReq_o.op < OP_COUNT)
	);

endmodule

/* rtl/aluPkg.sv */
// ====================
// execute unit package
// widths, opcodes and stage structs
// ====================
package aluPkg;

	typedef logic [15:0] word_t;	// data word
	typedef logic [7:0] byte_t;	// byte operand
	typedef logic [3:0] digit_t;	// one bcd digit
	typedef logic [4:0] aluOp_t;	// bit 0 selects byte form

	localparam int NUM_DIGITS = 4;	// bcd digits per word

	// word forms, the byte form adds one
	localparam aluOp_t OP_ADD  = 5'd0;
	localparam aluOp_t OP_ADDC = 5'd2;
	localparam aluOp_t OP_SUB  = 5'd4;
	localparam aluOp_t OP_SUBC = 5'd6;
	localparam aluOp_t OP_DADD = 5'd8;
	localparam aluOp_t OP_CMP  = 5'd10;
	localparam aluOp_t OP_XOR  = 5'd12;
	localparam aluOp_t OP_AND  = 5'd14;
	localparam aluOp_t OP_OR   = 5'd16;
	localparam aluOp_t OP_BIT  = 5'd18;
	localparam aluOp_t OP_BIC  = 5'd20;
	localparam aluOp_t OP_BIS  = 5'd22;
	localparam aluOp_t OP_SRA  = 5'd24;
	localparam aluOp_t OP_RRC  = 5'd26;

	localparam int OP_COUNT = 28;	// legal opcodes are below this

	// psw bits 4..0
	typedef struct packed {
		logic v;	// signed overflow
		logic s;	// held only
		logic n;	// negative
		logic z;	// zero
		logic c;	// carry / no borrow
	} flags_t;

	typedef struct packed {
		aluOp_t op;
		logic pswUpdate;	// write defined flags
		word_t src;
		word_t dst;
	} aluReq_t;

	// core result plus which flags the op defines
	typedef struct packed {
		word_t result;
		flags_t flags;
		logic cValid;
		logic vValid;
		logic nzValid;
	} aluOut_t;

endpackage
